// ==== build.f ====
source/tile_pkg.sv
source/credit_counter.sv
source/dispatch_ctrl.sv
source/issue_queue.sv
source/alu_pipe.sv
source/bru_pipe.sv
source/rob.sv
source/tile_core.sv
verification/tb_clkgen.sv
verification/tb_tile.sv

// ==== Makefile ====
# Verilator build and run for the tile testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module tb_tile -f build.f -o tb_tile

run: compile
	./obj_dir/tb_tile | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_tile.sv ====
`timescale 1ns/100ps

module tb_tile;

  localparam int          RST_CYCLES     = 16;
  localparam int          N_RAND         = 200;
  localparam int          N_BURST        = 120;
  localparam int          TIMEOUT_CYCLES = (N_RAND + N_BURST) * tile_pkg::ROB_SIZE * 8
                                           + RST_CYCLES;
  localparam logic [31:0] LFSR_SEED      = 32'h845c6f39;

  // Expected view of one group, in acceptance order
  typedef struct packed {
    logic [tile_pkg::CMT_ID_W-1:0]                        cmt_id;
    logic [tile_pkg::DISP_SIZE-1:0]                       slot_valid;
    logic [tile_pkg::DISP_SIZE-1:0]                       is_bru;
    logic [tile_pkg::DISP_SIZE-1:0][tile_pkg::DATA_W-1:0] result;
  } exp_grp_t;

  logic                          clk;
  logic                          rst_n;
  tile_pkg::disp_grp_t           disp;
  logic                          disp_ready;
  tile_pkg::commit_t             commit;

  logic [31:0]                   lfsr_state;
  exp_grp_t                      exp_q [$];
  exp_grp_t                      exp_head;
  logic [tile_pkg::CMT_ID_W-1:0] next_id;
  int                            outstanding;
  int                            alu_used;
  int                            bru_used;
  int                            accepted_total;
  int                            committed_total;
  int                            cycle_count;
  int                            errors;
  int                            tests_passed;
  int                            tests_failed;

  tb_clkgen #(.HALF_PERIOD(20), .RST_CYCLES(RST_CYCLES)) u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  tile_core u_tile_core (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_disp       (disp),
    .o_disp_ready (disp_ready),
    .o_commit     (commit)
  );

  // ------------------------------
  // Reference functions
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [1:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      tile_pkg::ALU_ADD: return a + b;
      tile_pkg::ALU_SUB: return a - b;
      tile_pkg::ALU_XOR: return a ^ b;
      default:           return a & b;
    endcase
  endfunction

  function automatic logic [31:0] bru_ref(input logic cond, input logic [31:0] a,
                                          input logic [31:0] b);
    if (cond == tile_pkg::BRU_EQ) begin
      return (a == b) ? 32'd1 : 32'd0;
    end
    return (a < b) ? 32'd1 : 32'd0;
  endfunction

  function automatic exp_grp_t build_expected(input tile_pkg::disp_grp_t g,
                                              input logic [tile_pkg::CMT_ID_W-1:0] id);
    exp_grp_t e;
    e = '0;
    e.cmt_id = id;
    for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
      e.slot_valid[d] = g.inst[d].valid;
      e.is_bru[d]     = (g.inst[d].cat == tile_pkg::CAT_BRU);
      if (e.is_bru[d]) begin
        e.result[d] = bru_ref(g.inst[d].op[0], g.inst[d].a, g.inst[d].b);
      end else begin
        e.result[d] = alu_ref(g.inst[d].op, g.inst[d].a, g.inst[d].b);
      end
    end
    return e;
  endfunction

  // Compares only the valid slots of one unit
  function automatic logic results_match(input tile_pkg::commit_t c, input exp_grp_t e,
                                         input logic bru);
    for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
      if (e.slot_valid[d] && (e.is_bru[d] == bru) && (c.result[d] != e.result[d])) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // One ROB entry plus a queue slot per valid instruction
  function automatic logic ready_rule(input tile_pkg::disp_grp_t g, input int rob_used,
                                      input int alu_q, input int bru_q);
    int n_alu;
    int n_bru;
    n_alu = 0;
    n_bru = 0;
    for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
      if (g.valid && g.inst[d].valid) begin
        if (g.inst[d].cat == tile_pkg::CAT_BRU) begin
          n_bru++;
        end else begin
          n_alu++;
        end
      end
    end
    return (rob_used < tile_pkg::ROB_SIZE) && (n_alu <= tile_pkg::ALU_RS_SIZE - alu_q) &&
           (n_bru <= tile_pkg::BRU_RS_SIZE - bru_q);
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  always @(posedge clk) begin : model
    logic accept;
    int   n_alu;
    int   n_bru;
    if (!rst_n) begin
      exp_q.delete();
      exp_head        <= '0;
      next_id         <= '0;
      outstanding     <= 0;
      alu_used        <= 0;
      bru_used        <= 0;
      accepted_total  <= 0;
      committed_total <= 0;
    end else begin
      accept = disp.valid && disp_ready;
      n_alu  = 0;
      n_bru  = 0;
      for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
        if (accept && disp.inst[d].valid) begin
          if (disp.inst[d].cat == tile_pkg::CAT_BRU) begin
            n_bru++;
          end else begin
            n_alu++;
          end
        end
      end
      if (commit.valid) begin
        committed_total <= committed_total + 1;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (accept) begin
        exp_q.push_back(build_expected(disp, next_id));
        next_id        <= next_id + 1'b1;
        accepted_total <= accepted_total + 1;
      end
      // Each queue issues its head every cycle it holds something
      alu_used    <= alu_used - ((alu_used != 0) ? 1 : 0) + n_alu;
      bru_used    <= bru_used - ((bru_used != 0) ? 1 : 0) + n_bru;
      outstanding <= exp_q.size();
      exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_reset_state: assert property (@(posedge clk)
    (rst_n && accepted_total == 0) |-> (!commit.valid && disp_ready))
    else begin
      errors++;
      $display("[ERROR] %0t: idle state after reset is wrong", $time);
    end

  a_commit_order: assert property (@(posedge clk)
    (rst_n && commit.valid) |-> (outstanding != 0 && commit.cmt_id == exp_head.cmt_id &&
                                 commit.slot_valid == exp_head.slot_valid))
    else begin
      errors++;
      $display("[ERROR] %0t: commit id %0d mask %b, expected id %0d mask %b", $time,
               $sampled(commit.cmt_id), $sampled(commit.slot_valid),
               $sampled(exp_head.cmt_id), $sampled(exp_head.slot_valid));
    end

  a_alu_result: assert property (@(posedge clk)
    (rst_n && commit.valid) |-> results_match(commit, exp_head, 1'b0))
    else begin
      errors++;
      $display("[ERROR] %0t: ALU result mismatch in group %0d", $time,
               $sampled(commit.cmt_id));
    end

  a_bru_result: assert property (@(posedge clk)
    (rst_n && commit.valid) |-> results_match(commit, exp_head, 1'b1))
    else begin
      errors++;
      $display("[ERROR] %0t: BRU result mismatch in group %0d", $time,
               $sampled(commit.cmt_id));
    end

  a_flow_ctrl: assert property (@(posedge clk)
    rst_n |-> (disp_ready == ready_rule(disp, outstanding, alu_used, bru_used)))
    else begin
      errors++;
      $display("[ERROR] %0t: ready %b with %0d groups open, ALU %0d, BRU %0d queued", $time,
               $sampled(disp_ready), $sampled(outstanding), $sampled(alu_used),
               $sampled(bru_used));
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles with %0d groups uncommitted",
               cycle_count, outstanding);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic make_group(output tile_pkg::disp_grp_t g);
    logic [31:0] v;
    logic [1:0]  mask;
    g       = '0;
    g.valid = 1'b1;
    take_bits(2, v);
    mask = (v[1:0] == 2'b00) ? 2'b11 : v[1:0];
    for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
      g.inst[d].valid = mask[d];
      take_bits(1, v);
      g.inst[d].cat = tile_pkg::inst_cat_e'(v[0]);
      take_bits(2, v);
      g.inst[d].op = v[1:0];
      take_bits(32, v);
      g.inst[d].a = v;
      take_bits(32, v);
      g.inst[d].b = v;
      // Equal operands now and then so EQ can hold
      take_bits(2, v);
      if (v[1:0] == 2'b00) begin
        g.inst[d].b = g.inst[d].a;
      end
    end
  endtask

  // Holds the group until the DUT takes it, ready looked at mid-cycle
  task automatic send_group(input tile_pkg::disp_grp_t g);
    disp <= g;
    do begin
      @(negedge clk);
    end while (!disp_ready);
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int n);
    disp <= '0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drain();
    disp <= '0;
    @(posedge clk);
    while (outstanding != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    if (errs == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errs);
    end
  endtask

  initial begin : stimulus
    tile_pkg::disp_grp_t g;
    logic [31:0]         v;
    int                  start_err;
    int                  gap;
    disp         = '0;
    lfsr_state   = LFSR_SEED;
    cycle_count  = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait (rst_n === 1'b1);
    @(posedge clk);

    start_err = errors;
    repeat (4) @(posedge clk);
    report_test(1, "reset_state", errors - start_err);

    // Random mix with idle gaps
    start_err = errors;
    for (int i = 0; i < N_RAND; i++) begin
      take_bits(2, v);
      gap = v[1] ? int'(v[0]) + 1 : 0;
      if (gap != 0) begin
        idle_cycles(gap);
      end
      make_group(g);
      send_group(g);
    end
    drain();
    report_test(2, "random_mix", errors - start_err);

    // Back-to-back groups to exhaust the credit pools
    start_err = errors;
    for (int i = 0; i < N_BURST; i++) begin
      make_group(g);
      send_group(g);
    end
    drain();
    a_all_committed: assert (committed_total == accepted_total)
      else begin
        errors++;
        $display("[ERROR] %0t: %0d groups accepted but %0d committed", $time,
                 accepted_total, committed_total);
      end
    report_test(3, "burst_flow", errors - start_err);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d, groups %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, errors,
             accepted_total);
    if (errors == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int HALF_PERIOD = 20,
  parameter int RST_CYCLES  = 16
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Released on an edge so the DUT sees a clean synchronous deassert
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

// ==== source/tile_core.sv ====
`timescale 1ns/100ps

module tile_core (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  tile_pkg::disp_grp_t   i_disp,
  output logic                  o_disp_ready,
  output tile_pkg::commit_t     o_commit
);

  logic                            w_accept;
  logic [tile_pkg::DISP_SIZE-1:0]  w_alu_push_mask;
  logic [tile_pkg::DISP_SIZE-1:0]  w_bru_push_mask;
  logic                            w_alu_return;
  logic                            w_bru_return;
  logic                            w_rob_return;
  logic [tile_pkg::CMT_ID_W-1:0]   w_new_cmt_id;
  tile_pkg::alu_entry_t            w_alu_entries [tile_pkg::DISP_SIZE];
  tile_pkg::bru_entry_t            w_bru_entries [tile_pkg::DISP_SIZE];
  logic                            w_alu_issue_valid;
  logic                            w_bru_issue_valid;
  tile_pkg::alu_entry_t            w_alu_issue_entry;
  tile_pkg::bru_entry_t            w_bru_issue_entry;
  tile_pkg::done_rpt_t             w_alu_done;
  tile_pkg::done_rpt_t             w_bru_done;

  // Tag each slot with the group id and its slot index
  for (genvar d = 0; d < tile_pkg::DISP_SIZE; d++) begin : g_entry
    assign w_alu_entries[d] = '{op:     tile_pkg::alu_op_e'(i_disp.inst[d].op),
                                a:      i_disp.inst[d].a,
                                b:      i_disp.inst[d].b,
                                cmt_id: w_new_cmt_id,
                                slot:   (tile_pkg::SLOT_W)'(d)};
    assign w_bru_entries[d] = '{cond:   tile_pkg::bru_cond_e'(i_disp.inst[d].op[0]),
                                a:      i_disp.inst[d].a,
                                b:      i_disp.inst[d].b,
                                cmt_id: w_new_cmt_id,
                                slot:   (tile_pkg::SLOT_W)'(d)};
  end

  dispatch_ctrl u_dispatch_ctrl (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_disp          (i_disp),
    .i_alu_return    (w_alu_return),
    .i_bru_return    (w_bru_return),
    .i_rob_return    (w_rob_return),
    .o_disp_ready    (o_disp_ready),
    .o_accept        (w_accept),
    .o_alu_push_mask (w_alu_push_mask),
    .o_bru_push_mask (w_bru_push_mask)
  );

  issue_queue #(
    .T_ENTRY (tile_pkg::alu_entry_t),
    .DEPTH   (tile_pkg::ALU_RS_SIZE)
  ) u_alu_queue (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_push_mask     (w_alu_push_mask),
    .i_entries       (w_alu_entries),
    .o_issue_valid   (w_alu_issue_valid),
    .o_issue_entry   (w_alu_issue_entry),
    .o_credit_return (w_alu_return)
  );

  issue_queue #(
    .T_ENTRY (tile_pkg::bru_entry_t),
    .DEPTH   (tile_pkg::BRU_RS_SIZE)
  ) u_bru_queue (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_push_mask     (w_bru_push_mask),
    .i_entries       (w_bru_entries),
    .o_issue_valid   (w_bru_issue_valid),
    .o_issue_entry   (w_bru_issue_entry),
    .o_credit_return (w_bru_return)
  );

  alu_pipe u_alu_pipe (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (w_alu_issue_valid),
    .i_entry (w_alu_issue_entry),
    .o_done  (w_alu_done)
  );

  bru_pipe u_bru_pipe (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (w_bru_issue_valid),
    .i_entry (w_bru_issue_entry),
    .o_done  (w_bru_done)
  );

  rob u_rob (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_accept     (w_accept),
    .i_disp       (i_disp),
    .i_alu_done   (w_alu_done),
    .i_bru_done   (w_bru_done),
    .o_new_cmt_id (w_new_cmt_id),
    .o_commit     (o_commit),
    .o_rob_return (w_rob_return)
  );

endmodule

// ==== source/rob.sv ====
`timescale 1ns/100ps

module rob (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_accept,
  input  tile_pkg::disp_grp_t             i_disp,
  input  tile_pkg::done_rpt_t             i_alu_done,
  input  tile_pkg::done_rpt_t             i_bru_done,
  output logic [tile_pkg::CMT_ID_W-1:0]   o_new_cmt_id,
  output tile_pkg::commit_t               o_commit,
  output logic                            o_rob_return
);

  logic [tile_pkg::ROB_SIZE-1:0]                         r_valid;
  logic [tile_pkg::DISP_SIZE-1:0]                        r_slot_valid [tile_pkg::ROB_SIZE];
  logic [tile_pkg::DISP_SIZE-1:0]                        r_done [tile_pkg::ROB_SIZE];
  logic [tile_pkg::DISP_SIZE-1:0][tile_pkg::DATA_W-1:0]  r_result [tile_pkg::ROB_SIZE];
  logic [tile_pkg::CMT_ID_W-1:0]                         r_head;
  logic [tile_pkg::CMT_ID_W-1:0]                         r_tail;
  logic [tile_pkg::DISP_SIZE-1:0]                        w_disp_mask;
  logic                                                  w_head_cmt;
  tile_pkg::commit_t                                     r_commit;

  always_comb begin
    for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
      w_disp_mask[d] = i_disp.inst[d].valid;
    end
  end

  // Head retires once every valid slot has reported
  assign w_head_cmt = r_valid[r_head] &&
                      (&(r_done[r_head] | ~r_slot_valid[r_head]));

  // ------------------------------
  // Entry state
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_valid <= '0;
      r_head  <= '0;
      r_tail  <= '0;
    end else begin
      if (i_accept) begin
        r_valid[r_tail] <= 1'b1;
        r_tail          <= r_tail + 1'b1;
      end
      if (w_head_cmt) begin
        r_valid[r_head] <= 1'b0;
        r_head          <= r_head + 1'b1;
      end
    end
  end

  // Allocation and done reports never target the same entry
  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      r_slot_valid[r_tail] <= w_disp_mask;
      r_done[r_tail]       <= '0;
    end
    if (i_alu_done.valid) begin
      r_done[i_alu_done.cmt_id][i_alu_done.slot]   <= 1'b1;
      r_result[i_alu_done.cmt_id][i_alu_done.slot] <= i_alu_done.result;
    end
    if (i_bru_done.valid) begin
      r_done[i_bru_done.cmt_id][i_bru_done.slot]   <= 1'b1;
      r_result[i_bru_done.cmt_id][i_bru_done.slot] <= i_bru_done.result;
    end
  end

  // ------------------------------
  // Commit
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_commit.valid <= 1'b0;
    end else begin
      r_commit.valid      <= w_head_cmt;
      r_commit.cmt_id     <= r_head;
      r_commit.slot_valid <= r_slot_valid[r_head];
      r_commit.result     <= r_result[r_head];
    end
  end

  assign o_commit     = r_commit;
  assign o_rob_return = r_commit.valid;
  assign o_new_cmt_id = r_tail;

endmodule

// ==== source/bru_pipe.sv ====
`timescale 1ns/100ps

module bru_pipe (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  tile_pkg::bru_entry_t   i_entry,
  output tile_pkg::done_rpt_t    o_done
);

  logic                          w_taken;
  logic                          r_ex1_valid;
  logic                          r_ex1_taken;
  logic [tile_pkg::CMT_ID_W-1:0] r_ex1_cmt_id;
  logic [tile_pkg::SLOT_W-1:0]   r_ex1_slot;
  tile_pkg::done_rpt_t           r_done;

  // Unsigned compare for LTU
  always_comb begin
    if (i_entry.cond == tile_pkg::BRU_EQ) begin
      w_taken = (i_entry.a == i_entry.b);
    end else begin
      w_taken = (i_entry.a < i_entry.b);
    end
  end

  // ------------------------------
  // EX1
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_taken  <= w_taken;
    r_ex1_cmt_id <= i_entry.cmt_id;
    r_ex1_slot   <= i_entry.slot;
  end

  // EX2, condition goes out in bit 0
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_done.valid <= 1'b0;
    end else begin
      r_done.valid  <= r_ex1_valid;
      r_done.cmt_id <= r_ex1_cmt_id;
      r_done.slot   <= r_ex1_slot;
      r_done.result <= {{(tile_pkg::DATA_W - 1){1'b0}}, r_ex1_taken};
    end
  end

  assign o_done = r_done;

endmodule

// ==== source/alu_pipe.sv ====
`timescale 1ns/100ps

module alu_pipe (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  tile_pkg::alu_entry_t   i_entry,
  output tile_pkg::done_rpt_t    o_done
);

  logic [tile_pkg::DATA_W-1:0]   w_result;
  logic                          r_ex1_valid;
  logic [tile_pkg::DATA_W-1:0]   r_ex1_result;
  logic [tile_pkg::CMT_ID_W-1:0] r_ex1_cmt_id;
  logic [tile_pkg::SLOT_W-1:0]   r_ex1_slot;
  tile_pkg::done_rpt_t           r_done;

  // Wraps at 32 bits
  always_comb begin
    case (i_entry.op)
      tile_pkg::ALU_ADD: w_result = i_entry.a + i_entry.b;
      tile_pkg::ALU_SUB: w_result = i_entry.a - i_entry.b;
      tile_pkg::ALU_XOR: w_result = i_entry.a ^ i_entry.b;
      default:           w_result = i_entry.a & i_entry.b;
    endcase
  end

  // ------------------------------
  // EX1
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_result <= w_result;
    r_ex1_cmt_id <= i_entry.cmt_id;
    r_ex1_slot   <= i_entry.slot;
  end

  // EX2 done report
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_done.valid <= 1'b0;
    end else begin
      r_done.valid  <= r_ex1_valid;
      r_done.cmt_id <= r_ex1_cmt_id;
      r_done.slot   <= r_ex1_slot;
      r_done.result <= r_ex1_result;
    end
  end

  assign o_done = r_done;

endmodule

// ==== source/issue_queue.sv ====
`timescale 1ns/100ps

module issue_queue #(
  parameter type T_ENTRY = logic,
  parameter int  DEPTH   = 4
) (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic [tile_pkg::DISP_SIZE-1:0]   i_push_mask,
  input  T_ENTRY                           i_entries [tile_pkg::DISP_SIZE],
  output logic                             o_issue_valid,
  output T_ENTRY                           o_issue_entry,
  output logic                             o_credit_return
);

  T_ENTRY                         r_mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]       r_head;
  logic [$clog2(DEPTH)-1:0]       r_tail;
  logic [$clog2(DEPTH + 1)-1:0]   r_count;
  logic [$clog2(DEPTH)-1:0]       w_ofs;
  logic [$clog2(DEPTH)-1:0]       w_wr_idx [tile_pkg::DISP_SIZE];
  logic [$clog2(DEPTH + 1)-1:0]   w_push_num;
  logic [$clog2(DEPTH + 1)-1:0]   w_count_next;

  // Masked slots pack into consecutive entries, slot 0 first
  always_comb begin
    w_ofs      = '0;
    w_push_num = '0;
    for (int s = 0; s < tile_pkg::DISP_SIZE; s++) begin
      w_wr_idx[s] = r_tail + w_ofs;
      if (i_push_mask[s]) begin
        w_ofs      = w_ofs + 1'b1;
        w_push_num = w_push_num + 1'b1;
      end
    end
    w_count_next = r_count + w_push_num;
    if (o_issue_valid) begin
      w_count_next = w_count_next - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int s = 0; s < tile_pkg::DISP_SIZE; s++) begin
      if (i_push_mask[s]) begin
        r_mem[w_wr_idx[s]] <= i_entries[s];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      r_tail  <= r_tail + w_ofs;
      r_count <= w_count_next;
      if (o_issue_valid) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  // Head is always the oldest entry
  assign o_issue_valid   = (r_count != '0);
  assign o_issue_entry   = r_mem[r_head];
  assign o_credit_return = o_issue_valid;

endmodule

// ==== source/dispatch_ctrl.sv ====
`timescale 1ns/100ps

module dispatch_ctrl (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  tile_pkg::disp_grp_t              i_disp,
  input  logic                             i_alu_return,
  input  logic                             i_bru_return,
  input  logic                             i_rob_return,
  output logic                             o_disp_ready,
  output logic                             o_accept,
  output logic [tile_pkg::DISP_SIZE-1:0]   o_alu_push_mask,
  output logic [tile_pkg::DISP_SIZE-1:0]   o_bru_push_mask
);

  logic [tile_pkg::DISP_SIZE-1:0] w_alu_mask;
  logic [tile_pkg::DISP_SIZE-1:0] w_bru_mask;
  logic [tile_pkg::ALU_CNT_W-1:0] w_alu_cnt;
  logic [tile_pkg::BRU_CNT_W-1:0] w_bru_cnt;
  logic [tile_pkg::ROB_CNT_W-1:0] w_rob_credit;
  logic [tile_pkg::ALU_CNT_W-1:0] w_alu_credit;
  logic [tile_pkg::BRU_CNT_W-1:0] w_bru_credit;

  // ------------------------------
  // Per-category slot count
  // ------------------------------
  always_comb begin
    w_alu_cnt = '0;
    w_bru_cnt = '0;
    for (int d = 0; d < tile_pkg::DISP_SIZE; d++) begin
      w_alu_mask[d] = i_disp.valid && i_disp.inst[d].valid &&
                      (i_disp.inst[d].cat == tile_pkg::CAT_ALU);
      w_bru_mask[d] = i_disp.valid && i_disp.inst[d].valid &&
                      (i_disp.inst[d].cat == tile_pkg::CAT_BRU);
      if (w_alu_mask[d]) begin
        w_alu_cnt = w_alu_cnt + 1'b1;
      end
      if (w_bru_mask[d]) begin
        w_bru_cnt = w_bru_cnt + 1'b1;
      end
    end
  end

  // One ROB entry plus a queue slot per instruction
  assign o_disp_ready = (w_rob_credit != '0) &&
                        (w_alu_cnt <= w_alu_credit) &&
                        (w_bru_cnt <= w_bru_credit);

  assign o_accept        = i_disp.valid && o_disp_ready;
  assign o_alu_push_mask = w_alu_mask & {tile_pkg::DISP_SIZE{o_accept}};
  assign o_bru_push_mask = w_bru_mask & {tile_pkg::DISP_SIZE{o_accept}};

  // ------------------------------
  // Credit pools
  // ------------------------------
  credit_counter #(.MAX_CREDIT(tile_pkg::ROB_SIZE)) u_rob_credit (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_alloc_num ({{(tile_pkg::ROB_CNT_W - 1){1'b0}}, o_accept}),
    .i_return    (i_rob_return),
    .o_credit    (w_rob_credit)
  );

  credit_counter #(.MAX_CREDIT(tile_pkg::ALU_RS_SIZE)) u_alu_credit (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_alloc_num (o_accept ? w_alu_cnt : '0),
    .i_return    (i_alu_return),
    .o_credit    (w_alu_credit)
  );

  credit_counter #(.MAX_CREDIT(tile_pkg::BRU_RS_SIZE)) u_bru_credit (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_alloc_num (o_accept ? w_bru_cnt : '0),
    .i_return    (i_bru_return),
    .o_credit    (w_bru_credit)
  );

endmodule

// ==== source/credit_counter.sv ====
`timescale 1ns/100ps

module credit_counter #(
  parameter int MAX_CREDIT = 4
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic [$clog2(MAX_CREDIT + 1)-1:0]   i_alloc_num,
  input  logic                                i_return,
  output logic [$clog2(MAX_CREDIT + 1)-1:0]   o_credit
);

  logic [$clog2(MAX_CREDIT + 1)-1:0] r_credit;
  logic [$clog2(MAX_CREDIT + 1)-1:0] w_credit_next;

  // Allocation and return may land in the same cycle
  always_comb begin
    w_credit_next = r_credit - i_alloc_num;
    if (i_return) begin
      w_credit_next = w_credit_next + 1'b1;
    end
  end

  // Pool starts full
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_credit <= ($clog2(MAX_CREDIT + 1))'(MAX_CREDIT);
    end else begin
      r_credit <= w_credit_next;
    end
  end

  assign o_credit = r_credit;

endmodule

// ==== source/tile_pkg.sv ====
package tile_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int DISP_SIZE   = 2;
  localparam int DATA_W      = 32;
  localparam int ROB_SIZE    = 8;
  localparam int CMT_ID_W    = 3;
  localparam int ALU_RS_SIZE = 4;
  localparam int BRU_RS_SIZE = 4;

  // Slot index within a group
  localparam int SLOT_W = 1;

  // Credit counter widths, wide enough to hold a full pool
  localparam int ROB_CNT_W = $clog2(ROB_SIZE + 1);
  localparam int ALU_CNT_W = $clog2(ALU_RS_SIZE + 1);
  localparam int BRU_CNT_W = $clog2(BRU_RS_SIZE + 1);

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic {
    CAT_ALU = 1'b0,
    CAT_BRU = 1'b1
  } inst_cat_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_XOR = 2'b10,
    ALU_AND = 2'b11
  } alu_op_e;

  typedef enum logic {
    BRU_EQ  = 1'b0,
    BRU_LTU = 1'b1
  } bru_cond_e;

  // ------------------------------
  // Shared structs
  // ------------------------------
  // Op field holds alu_op_e or bru_cond_e depending on cat
  typedef struct packed {
    logic              valid;
    inst_cat_e         cat;
    logic [1:0]        op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } disp_inst_t;

  typedef struct packed {
    logic                        valid;
    disp_inst_t [DISP_SIZE-1:0]  inst;
  } disp_grp_t;

  typedef struct packed {
    alu_op_e             op;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [SLOT_W-1:0]   slot;
  } alu_entry_t;

  typedef struct packed {
    bru_cond_e           cond;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [SLOT_W-1:0]   slot;
  } bru_entry_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [SLOT_W-1:0]   slot;
    logic [DATA_W-1:0]   result;
  } done_rpt_t;

  typedef struct packed {
    logic                               valid;
    logic [CMT_ID_W-1:0]                cmt_id;
    logic [DISP_SIZE-1:0]               slot_valid;
    logic [DISP_SIZE-1:0][DATA_W-1:0]   result;
  } commit_t;

endpackage
